/* hw/id_serialize_pkg.sv */
/* ID serializer shared definitions
   Channel widths and the AR/R payload structs for both ports */
`default_nettype none

package id_serialize_pkg;

  // Port widths
  localparam int unsigned SLV_ID_W = 4;
  localparam int unsigned MST_ID_W = 2;
  localparam int unsigned ADDR_W   = 16;
  localparam int unsigned DATA_W   = 32;
  localparam int unsigned LEN_W    = 8;

  typedef logic [SLV_ID_W-1:0] slv_id_t;
  typedef logic [MST_ID_W-1:0] mst_id_t;
  typedef logic [ADDR_W-1:0]   addr_t;
  typedef logic [DATA_W-1:0]   data_t;
  typedef logic [LEN_W-1:0]    len_t;

  // AR channel at the slave port, 28 bits
  typedef struct packed {
    slv_id_t id;
    addr_t   addr;
    len_t    len;
  } slv_ar_t;

  // AR channel at the master port, 26 bits
  typedef struct packed {
    mst_id_t id;
    addr_t   addr;
    len_t    len;
  } mst_ar_t;

  // R channel at the slave port, 37 bits
  typedef struct packed {
    slv_id_t id;
    data_t   data;
    logic    last;
  } slv_r_t;

  // R channel at the master port, 35 bits
  typedef struct packed {
    mst_id_t id;
    data_t   data;
    logic    last;
  } mst_r_t;

endpackage

`default_nettype wire

/* hw/id_lane.sv */
/* Serialization lane for one master ID
   One-entry AR buffer plus the held slave ID and the count of reads in flight */
`timescale 1ns/1ps
`default_nettype none

module id_lane
  import id_serialize_pkg::*;
#(
  parameter int unsigned LANE_IDX        = 0,
  parameter int unsigned NUM_UNIQ_IDS    = 3,
  parameter int unsigned MAX_TXNS_PER_ID = 2
) (
  input  wire            clk_i,
  input  wire            reset_i,
  input  wire slv_ar_t   slv_ar_i,
  input  wire            slv_ar_valid_i,
  input  wire            grant_i,
  input  wire            r_done_i,
  output logic           ar_ready_o,
  output logic           req_o,
  output mst_ar_t        lane_ar_o,
  output logic [SLV_ID_W-1:0] held_id_o
);

  localparam int unsigned CNT_W = $clog2(MAX_TXNS_PER_ID + 1);

  logic             lane_hit;
  logic             id_ok;
  logic             admit;
  logic             buf_full_q;
  mst_ar_t          buf_q;
  logic [CNT_W-1:0] cnt_q;
  slv_id_t          held_id_q;

  // Request belongs here when its ID folds onto this lane index
  assign lane_hit = ((32'(slv_ar_i.id) % NUM_UNIQ_IDS) == LANE_IDX);

  // Idle lane takes any ID; a busy lane only more of the same ID, up to the limit
  always_comb begin
    if (cnt_q == '0) begin
      id_ok = 1'b1;
    end else begin
      id_ok = (held_id_q == slv_ar_i.id) && (cnt_q < CNT_W'(MAX_TXNS_PER_ID));
    end
  end

  assign ar_ready_o = lane_hit && !buf_full_q && id_ok;
  assign admit      = ar_ready_o && slv_ar_valid_i;

  // Buffer occupancy, emptied when the arbiter takes the entry
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      buf_full_q <= 1'b0;
    end else if (admit) begin
      buf_full_q <= 1'b1;
    end else if (grant_i) begin
      buf_full_q <= 1'b0;
    end
  end

  // Buffered payload with the narrow lane ID
  always_ff @(posedge clk_i) begin
    if (admit) begin
      buf_q.id   <= MST_ID_W'(LANE_IDX);
      buf_q.addr <= slv_ar_i.addr;
      buf_q.len  <= slv_ar_i.len;
    end
  end

  // In-flight count, from admission to the last R beat
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      cnt_q <= '0;
    end else begin
      case ({admit, r_done_i})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: cnt_q <= cnt_q;
      endcase
    end
  end

  // Only meaningful while the count is nonzero
  always_ff @(posedge clk_i) begin
    if (admit) begin
      held_id_q <= slv_ar_i.id;
    end
  end

  assign req_o     = buf_full_q;
  assign lane_ar_o = buf_q;
  assign held_id_o = held_id_q;

endmodule

`default_nettype wire

/* hw/ar_arbiter.sv */
/* Round-robin AR arbiter
   Picks among full lane buffers and loads a registered master AR slot */
`timescale 1ns/1ps
`default_nettype none

module ar_arbiter
  import id_serialize_pkg::*;
#(
  parameter int unsigned NUM_UNIQ_IDS = 3
) (
  input  wire                              clk_i,
  input  wire                              reset_i,
  input  wire [NUM_UNIQ_IDS-1:0]           req_i,
  input  wire mst_ar_t [NUM_UNIQ_IDS-1:0]  lane_ar_i,
  input  wire                              mst_ar_ready_i,
  output logic [NUM_UNIQ_IDS-1:0]          grant_o,
  output mst_ar_t                          mst_ar_o,
  output logic                             mst_ar_valid_o
);

  typedef enum logic {
    SLOT_EMPTY = 1'b0,
    SLOT_FULL  = 1'b1
  } slot_state_e;

  slot_state_e state_q;
  slot_state_e state_d;
  mst_id_t     last_q;
  mst_id_t     pick;
  logic        found;
  logic        load;
  mst_ar_t     slot_q;

  // First requester after the last granted lane
  always_comb begin
    int unsigned idx;
    found = 1'b0;
    pick  = last_q;
    for (int unsigned off = 1; off <= NUM_UNIQ_IDS; off++) begin
      idx = (32'(last_q) + off) % NUM_UNIQ_IDS;
      if (!found && req_i[idx]) begin
        found = 1'b1;
        pick  = MST_ID_W'(idx);
      end
    end
  end

  // Slot can take a new request when empty or draining this cycle
  assign load = found && ((state_q == SLOT_EMPTY) || mst_ar_ready_i);

  always_comb begin
    grant_o = '0;
    if (load) begin
      grant_o[pick] = 1'b1;
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      SLOT_EMPTY: begin
        if (load) begin
          state_d = SLOT_FULL;
        end
      end
      SLOT_FULL: begin
        if (mst_ar_ready_i && !load) begin
          state_d = SLOT_EMPTY;
        end
      end
      default: state_d = SLOT_EMPTY;
    endcase
  end

  // Pointer starts on the top lane so lane 0 wins first
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= SLOT_EMPTY;
      last_q  <= MST_ID_W'(NUM_UNIQ_IDS - 1);
    end else begin
      state_q <= state_d;
      if (load) begin
        last_q <= pick;
      end
    end
  end

  // Master ID is the lane index
  always_ff @(posedge clk_i) begin
    if (load) begin
      slot_q      <= lane_ar_i[pick];
      slot_q.id   <= pick;
    end
  end

  assign mst_ar_o       = slot_q;
  assign mst_ar_valid_o = (state_q == SLOT_FULL);

endmodule

`default_nettype wire

/* hw/r_return.sv */
/* Read response return path
   Maps master R beats back to their lane and restores the slave ID */
`timescale 1ns/1ps
`default_nettype none

module r_return
  import id_serialize_pkg::*;
#(
  parameter int unsigned NUM_UNIQ_IDS = 3
) (
  input  wire mst_r_t                          mst_r_i,
  input  wire                                  mst_r_valid_i,
  input  wire                                  slv_r_ready_i,
  input  wire [NUM_UNIQ_IDS-1:0][SLV_ID_W-1:0] held_ids_i,
  output slv_r_t                               slv_r_o,
  output logic                                 slv_r_valid_o,
  output logic                                 mst_r_ready_o,
  output logic [NUM_UNIQ_IDS-1:0]              r_done_o
);

  logic    beat_xfer;
  slv_id_t orig_id;

  // Master ID is the lane index; out-of-range IDs never carry a live read
  always_comb begin
    orig_id = '0;
    if (32'(mst_r_i.id) < NUM_UNIQ_IDS) begin
      orig_id = held_ids_i[mst_r_i.id];
    end
  end

  always_comb begin
    slv_r_o.id   = orig_id;
    slv_r_o.data = mst_r_i.data;
    slv_r_o.last = mst_r_i.last;
  end

  // Handshake passes straight through
  assign slv_r_valid_o = mst_r_valid_i;
  assign mst_r_ready_o = slv_r_ready_i;
  assign beat_xfer     = mst_r_valid_i && slv_r_ready_i;

  // Last beat retires one read from its lane
  always_comb begin
    for (int unsigned k = 0; k < NUM_UNIQ_IDS; k++) begin
      r_done_o[k] = beat_xfer && mst_r_i.last && (32'(mst_r_i.id) == k);
    end
  end

endmodule

`default_nettype wire

/* hw/axi_id_serialize_rd.sv */
/* Read-only AXI ID serializer
   Folds wide slave IDs onto NUM_UNIQ_IDS lanes, one slave ID per lane at a time */
`timescale 1ns/1ps
`default_nettype none

module axi_id_serialize_rd
  import id_serialize_pkg::*;
#(
  parameter int unsigned NUM_UNIQ_IDS    = 3,
  parameter int unsigned MAX_TXNS_PER_ID = 2
) (
  input  wire          clk_i,
  input  wire          reset_i,
  // Slave AR
  input  wire slv_ar_t slv_ar_i,
  input  wire          slv_ar_valid_i,
  output logic         slv_ar_ready_o,
  // Slave R
  input  wire          slv_r_ready_i,
  output slv_r_t       slv_r_o,
  output logic         slv_r_valid_o,
  // Master AR
  input  wire          mst_ar_ready_i,
  output mst_ar_t      mst_ar_o,
  output logic         mst_ar_valid_o,
  // Master R
  input  wire mst_r_t  mst_r_i,
  input  wire          mst_r_valid_i,
  output logic         mst_r_ready_o
);

  logic    [NUM_UNIQ_IDS-1:0]               lane_ready;
  logic    [NUM_UNIQ_IDS-1:0]               lane_req;
  logic    [NUM_UNIQ_IDS-1:0]               lane_grant;
  logic    [NUM_UNIQ_IDS-1:0]               lane_done;
  mst_ar_t [NUM_UNIQ_IDS-1:0]               lane_ar;
  logic    [NUM_UNIQ_IDS-1:0][SLV_ID_W-1:0] lane_held_id;

  // One lane per master ID
  for (genvar i = 0; i < NUM_UNIQ_IDS; i++) begin : gen_lanes
    id_lane #(
      .LANE_IDX        ( i               ),
      .NUM_UNIQ_IDS    ( NUM_UNIQ_IDS    ),
      .MAX_TXNS_PER_ID ( MAX_TXNS_PER_ID )
    ) i_id_lane (
      .clk_i          ( clk_i           ),
      .reset_i        ( reset_i         ),
      .slv_ar_i       ( slv_ar_i        ),
      .slv_ar_valid_i ( slv_ar_valid_i  ),
      .grant_i        ( lane_grant[i]   ),
      .r_done_i       ( lane_done[i]    ),
      .ar_ready_o     ( lane_ready[i]   ),
      .req_o          ( lane_req[i]     ),
      .lane_ar_o      ( lane_ar[i]      ),
      .held_id_o      ( lane_held_id[i] )
    );
  end

  // Only the addressed lane can be ready, so the OR acts as the demux
  assign slv_ar_ready_o = |lane_ready;

  ar_arbiter #(
    .NUM_UNIQ_IDS ( NUM_UNIQ_IDS )
  ) i_ar_arbiter (
    .clk_i          ( clk_i          ),
    .reset_i        ( reset_i        ),
    .req_i          ( lane_req       ),
    .lane_ar_i      ( lane_ar        ),
    .mst_ar_ready_i ( mst_ar_ready_i ),
    .grant_o        ( lane_grant     ),
    .mst_ar_o       ( mst_ar_o       ),
    .mst_ar_valid_o ( mst_ar_valid_o )
  );

  r_return #(
    .NUM_UNIQ_IDS ( NUM_UNIQ_IDS )
  ) i_r_return (
    .mst_r_i       ( mst_r_i       ),
    .mst_r_valid_i ( mst_r_valid_i ),
    .slv_r_ready_i ( slv_r_ready_i ),
    .held_ids_i    ( lane_held_id  ),
    .slv_r_o       ( slv_r_o       ),
    .slv_r_valid_o ( slv_r_valid_o ),
    .mst_r_ready_o ( mst_r_ready_o ),
    .r_done_o      ( lane_done     )
  );

endmodule

`default_nettype wire

/* bench/tb_id_serialize_assert.sv */
/* Protocol checks bound into the read ID serializer
   AR hold under back-pressure, R pass-through and the state after reset */
`timescale 1ns/1ps
`default_nettype none

module tb_id_serialize_assert
  import id_serialize_pkg::*;
#(
  parameter int unsigned NUM_UNIQ_IDS = 3
) (
  input wire          clk_i,
  input wire          reset_i,
  input wire          slv_ar_ready_o,
  input wire          slv_r_ready_i,
  input wire          slv_r_valid_o,
  input wire          mst_ar_ready_i,
  input wire mst_ar_t mst_ar_o,
  input wire          mst_ar_valid_o,
  input wire          mst_r_valid_i,
  input wire          mst_r_ready_o
);

  int unsigned fail_cnt = 0;

  // Master AR request holds until the handshake
  ar_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    mst_ar_valid_o && !mst_ar_ready_i |=> mst_ar_valid_o && $stable(mst_ar_o))
    else begin
      $error("master AR valid dropped or payload changed before the handshake");
      fail_cnt++;
    end

  // Master ID must name an existing lane
  ar_id_range: assert property (@(posedge clk_i) disable iff (reset_i)
    mst_ar_valid_o |-> 32'(mst_ar_o.id) < NUM_UNIQ_IDS)
    else begin
      $error("master AR id outside the lane range");
      fail_cnt++;
    end

  // R handshake is a zero-cycle pass-through
  r_pass: assert property (@(posedge clk_i) disable iff (reset_i)
    (slv_r_valid_o == mst_r_valid_i) && (mst_r_ready_o == slv_r_ready_i))
    else begin
      $error("R valid or ready does not follow its source in the same cycle");
      fail_cnt++;
    end

  reset_state: assert property (@(posedge clk_i)
    $fell(reset_i) |-> !mst_ar_valid_o && slv_ar_ready_o)
    else begin
      $error("master AR valid set or slave AR ready low right after reset");
      fail_cnt++;
    end

endmodule

`default_nettype wire

/* bench/tb_id_serialize.sv */
/* Testbench for the read-only AXI ID serializer
   Random AR traffic, an in-order memory responder and a per-ID scoreboard */
`timescale 1ns/1ps
`default_nettype none

module tb_id_serialize
  import id_serialize_pkg::*;
();

  localparam int unsigned NUM_UNIQ_IDS    = 3;
  localparam int unsigned MAX_TXNS_PER_ID = 2;
  localparam int unsigned NUM_TXNS        = 400;
  localparam int unsigned TIMEOUT_CYC     = NUM_TXNS * 60;
  localparam int unsigned NUM_SLV_IDS     = 2 ** SLV_ID_W;

  logic    clk_i = 1'b0;
  logic    reset_i;
  slv_ar_t slv_ar_i;
  logic    slv_ar_valid_i;
  logic    slv_ar_ready_o;
  logic    slv_r_ready_i;
  slv_r_t  slv_r_o;
  logic    slv_r_valid_o;
  logic    mst_ar_ready_i;
  mst_ar_t mst_ar_o;
  logic    mst_ar_valid_o;
  mst_r_t  mst_r_i;
  logic    mst_r_valid_i;
  logic    mst_r_ready_o;

  // Scoreboard and responder state
  slv_ar_t     fwd_q [NUM_UNIQ_IDS][$];
  slv_ar_t     exp_q [NUM_SLV_IDS][$];
  mst_ar_t     rsp_q [NUM_UNIQ_IDS][$];
  int unsigned beat_no [NUM_SLV_IDS];
  int unsigned lane_out [NUM_UNIQ_IDS];
  slv_id_t     lane_id [NUM_UNIQ_IDS];
  mst_ar_t     rsp_req;
  logic        rsp_busy;
  int unsigned rsp_beat;
  logic        ar_xfer;
  logic        mar_xfer;
  logic        r_xfer;
  int unsigned issued;
  int unsigned done_cnt;
  int unsigned cycle;
  int unsigned mism_cnt;
  int unsigned other_cnt;
  logic [31:0] rng_state = 32'h110d_7838;

  always #50 clk_i = ~clk_i;

  axi_id_serialize_rd uut (
    .clk_i          ( clk_i          ),
    .reset_i        ( reset_i        ),
    .slv_ar_i       ( slv_ar_i       ),
    .slv_ar_valid_i ( slv_ar_valid_i ),
    .slv_ar_ready_o ( slv_ar_ready_o ),
    .slv_r_ready_i  ( slv_r_ready_i  ),
    .slv_r_o        ( slv_r_o        ),
    .slv_r_valid_o  ( slv_r_valid_o  ),
    .mst_ar_ready_i ( mst_ar_ready_i ),
    .mst_ar_o       ( mst_ar_o       ),
    .mst_ar_valid_o ( mst_ar_valid_o ),
    .mst_r_i        ( mst_r_i        ),
    .mst_r_valid_i  ( mst_r_valid_i  ),
    .mst_r_ready_o  ( mst_r_ready_o  )
  );

  bind axi_id_serialize_rd tb_id_serialize_assert #(
    .NUM_UNIQ_IDS ( NUM_UNIQ_IDS )
  ) i_assert (
    .clk_i          ( clk_i          ),
    .reset_i        ( reset_i        ),
    .slv_ar_ready_o ( slv_ar_ready_o ),
    .slv_r_ready_i  ( slv_r_ready_i  ),
    .slv_r_valid_o  ( slv_r_valid_o  ),
    .mst_ar_ready_i ( mst_ar_ready_i ),
    .mst_ar_o       ( mst_ar_o       ),
    .mst_ar_valid_o ( mst_ar_valid_o ),
    .mst_r_valid_i  ( mst_r_valid_i  ),
    .mst_r_ready_o  ( mst_r_ready_o  )
  );

  function automatic logic [31:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  // Blocks of 16 requests: IDs 1 and 4 alternating, a stream of ID 6, then random
  function automatic slv_id_t pick_id(int unsigned n);
    case ((n / 16) % 3)
      0:       return ((n % 2) != 0) ? 4'd4 : 4'd1;
      1:       return 4'd6;
      default: return SLV_ID_W'(next_rand());
    endcase
  endfunction

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    assert (got === exp) else begin
      $display("mismatch %s: got %h expected %h", name, got, exp);
      mism_cnt++;
    end
  endtask

  task automatic require_rule(input logic ok, input string what);
    assert (ok) else begin
      $display("%s", what);
      other_cnt++;
    end
  endtask

  task automatic accept_request(input slv_ar_t req);
    int unsigned ln;
    ln = int'(req.id) % NUM_UNIQ_IDS;
    if (lane_out[ln] != 0) begin
      require_rule(req.id == lane_id[ln], $sformatf(
        "Lane %0d accepted ID %0d while ID %0d was outstanding", ln, req.id, lane_id[ln]));
    end
    lane_out[ln]++;
    lane_id[ln] = req.id;
    require_rule(lane_out[ln] <= MAX_TXNS_PER_ID, $sformatf(
      "Lane %0d has more than %0d reads outstanding", ln, MAX_TXNS_PER_ID));
    fwd_q[ln].push_back(req);
    exp_q[req.id].push_back(req);
  endtask

  // Paired on payload so that a wrong id still finds the request it carries
  task automatic forward_request(input mst_ar_t ar);
    slv_ar_t     exp;
    logic        found;
    int unsigned hit;
    found = 1'b0;
    hit   = 0;
    for (int unsigned k = 0; k < NUM_UNIQ_IDS; k++) begin
      if (fwd_q[k].size() != 0 && fwd_q[k][0].addr == ar.addr &&
          fwd_q[k][0].len == ar.len && (!found || 32'(ar.id) == k)) begin
        found = 1'b1;
        hit   = k;
      end
    end
    if (found) begin
      exp = fwd_q[hit].pop_front();
      compare_value("mst_ar_o.id", ar.id, int'(exp.id) % NUM_UNIQ_IDS);
    end else if (32'(ar.id) < NUM_UNIQ_IDS && fwd_q[ar.id].size() != 0) begin
      exp = fwd_q[ar.id].pop_front();
      compare_value("mst_ar_o.addr", ar.addr, exp.addr);
      compare_value("mst_ar_o.len", ar.len, exp.len);
    end else begin
      require_rule(1'b0, "Master AR appeared with no pending request to match");
    end
    if (32'(ar.id) < NUM_UNIQ_IDS) begin
      rsp_q[ar.id].push_back(ar);
    end else begin
      require_rule(1'b0, "Master AR carries an id that names no lane");
    end
  endtask

  // Lane is known from the master side, its slave ID from the accept history
  task automatic return_beat(input slv_r_t r, input mst_id_t ln);
    slv_id_t exp_id;
    slv_ar_t exp;
    exp_id = lane_id[ln];
    compare_value("slv_r_o.id", r.id, exp_id);
    if (exp_q[exp_id].size() == 0) begin
      require_rule(1'b0, "R beat returned for a lane with no outstanding read");
    end else begin
      exp = exp_q[exp_id][0];
      compare_value("slv_r_o.data", r.data, DATA_W'(exp.addr) + beat_no[exp_id]);
      compare_value("slv_r_o.last", r.last, beat_no[exp_id] == int'(exp.len));
      if (beat_no[exp_id] == int'(exp.len)) begin
        void'(exp_q[exp_id].pop_front());
        beat_no[exp_id] = 0;
        lane_out[ln]--;
        done_cnt++;
      end else begin
        beat_no[exp_id]++;
      end
    end
  endtask

  // Sampled mid-cycle, these are the transfers of the coming edge
  task automatic observe_cycle();
    ar_xfer  = slv_ar_valid_i && slv_ar_ready_o;
    mar_xfer = mst_ar_valid_o && mst_ar_ready_i;
    r_xfer   = slv_r_valid_o && slv_r_ready_i;
    if (ar_xfer) begin
      accept_request(slv_ar_i);
    end
    if (mar_xfer) begin
      forward_request(mst_ar_o);
    end
    if (r_xfer && 32'(mst_r_i.id) < NUM_UNIQ_IDS) begin
      return_beat(slv_r_o, mst_r_i.id);
    end
  endtask

  task automatic drive_inputs();
    logic [31:0] rnd;
    int unsigned start;
    int unsigned ln;
    if (ar_xfer || !slv_ar_valid_i) begin
      slv_ar_valid_i = 1'b0;
      if (issued < NUM_TXNS && (next_rand() % 4) != 0) begin
        rnd = next_rand();
        slv_ar_i.id    = pick_id(issued);
        slv_ar_i.addr  = rnd[15:0];
        slv_ar_i.len   = LEN_W'(rnd[17:16]);
        slv_ar_valid_i = 1'b1;
        issued++;
      end
    end
    mst_ar_ready_i = (next_rand() % 3) != 0;
    slv_r_ready_i  = (next_rand() % 4) != 0;
    if (r_xfer) begin
      mst_r_valid_i = 1'b0;
      if (rsp_beat == int'(rsp_req.len)) begin
        rsp_busy = 1'b0;
      end else begin
        rsp_beat++;
      end
    end
    // Responder stalls new bursts for a quarter of the time
    if (!rsp_busy && (cycle % 160) >= 40) begin
      start = next_rand() % NUM_UNIQ_IDS;
      for (int unsigned k = 0; k < NUM_UNIQ_IDS; k++) begin
        ln = (start + k) % NUM_UNIQ_IDS;
        if (!rsp_busy && rsp_q[ln].size() != 0) begin
          rsp_req  = rsp_q[ln].pop_front();
          rsp_busy = 1'b1;
          rsp_beat = 0;
        end
      end
    end
    if (rsp_busy && !mst_r_valid_i && (next_rand() % 3) != 0) begin
      mst_r_i.id    = rsp_req.id;
      mst_r_i.data  = DATA_W'(rsp_req.addr) + DATA_W'(rsp_beat);
      mst_r_i.last  = (rsp_beat == int'(rsp_req.len));
      mst_r_valid_i = 1'b1;
    end
  endtask

  initial begin
    reset_i        = 1'b1;
    slv_ar_i       = '0;
    slv_ar_valid_i = 1'b0;
    slv_r_ready_i  = 1'b0;
    mst_ar_ready_i = 1'b0;
    mst_r_i        = '0;
    mst_r_valid_i  = 1'b0;
    rsp_req        = '0;
    rsp_busy       = 1'b0;
    rsp_beat       = 0;
    ar_xfer        = 1'b0;
    mar_xfer       = 1'b0;
    r_xfer         = 1'b0;
    issued         = 0;
    done_cnt       = 0;
    cycle          = 0;
    mism_cnt       = 0;
    other_cnt      = 0;
    for (int unsigned i = 0; i < NUM_SLV_IDS; i++) begin
      beat_no[i] = 0;
    end
    for (int unsigned i = 0; i < NUM_UNIQ_IDS; i++) begin
      lane_out[i] = 0;
      lane_id[i]  = '0;
    end
    repeat (3) @(posedge clk_i);
    #5;
    reset_i = 1'b0;
    while (done_cnt < NUM_TXNS && cycle < TIMEOUT_CYC) begin
      @(negedge clk_i);
      observe_cycle();
      @(posedge clk_i);
      #5;
      drive_inputs();
      cycle++;
    end
    if (done_cnt != NUM_TXNS) begin
      $display("Timeout after %0d cycles with %0d of %0d reads completed",
               cycle, done_cnt, NUM_TXNS);
      other_cnt++;
    end
    $display("Errors: %0d mismatches, %0d other failures, %0d assertion failures",
             mism_cnt, other_cnt, uut.i_assert.fail_cnt);
    if (mism_cnt + other_cnt + uut.i_assert.fail_cnt == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* tb.f */
hw/id_serialize_pkg.sv
hw/id_lane.sv
hw/ar_arbiter.sv
hw/r_return.sv
hw/axi_id_serialize_rd.sv
bench/tb_id_serialize_assert.sv
bench/tb_id_serialize.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the ID serializer testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_id_serialize -f tb.f -o Vtb_id_serialize
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

# Keep running past assertion errors so the testbench prints its summary
./obj_dir/Vtb_id_serialize +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Simulation failed" "$LOG"; then
  exit 1
fi
if ! grep -q "Simulation passed" "$LOG"; then
  echo "No result line found in $LOG"
  exit 1
fi
exit 0
